// File: build.f
sid_pkg.sv
uart_rx.sv
cmd_assembler.sv
write_fifo.sv
sid_regbank.sv
sigma_delta_dac.sv
sid_board.sv
tb_checker.sv
tb_sid_board.sv

// File: cmd_assembler.sv
module cmd_assembler
	import sid_pkg::*;
#(
	parameter int CLKS_PER_BIT = 16
) (
	input  logic             CLK_IN,
	input  logic             RSTn_i,
	input  logic             rx,
	input  logic             wr_ack,
	output logic             wr_req,
	output logic [CMD_W-1:0] wr_cmd
);

	typedef enum logic {
		S_ADDR,	// next byte is an address
		S_DATA	// next byte is data for the held address
	} pair_state_t;

	pair_state_t         state;
	logic [7:0]          rx_byte;
	logic                rx_valid;
	logic [REG_ADDR_W:0] addr_q;	// {chip select, register}
	logic                hs_idle;	// previous command fully handed over

	uart_rx #(
		.CLKS_PER_BIT(CLKS_PER_BIT)
	) u_uart_rx (
		.CLK_IN  (CLK_IN),
		.RSTn_i  (RSTn_i),
		.rx      (rx),
		.rx_byte (rx_byte),
		.rx_valid(rx_valid)
	);

	// four-phase rule, a new req only after ack has dropped
	assign hs_idle = !wr_req && !wr_ack;

	always_ff @(posedge CLK_IN) begin
		if (!RSTn_i) begin
			state  <= S_ADDR;
			wr_req <= 1'b0;
		end else begin
			if (wr_req && wr_ack)
				wr_req <= 1'b0;	// fifo took it, release req
			if (rx_valid) begin
				case (state)
					S_ADDR: begin
						addr_q <= {rx_byte[CHIP_SEL_BIT], rx_byte[REG_ADDR_W-1:0]};
						state  <= S_DATA;
					end
					S_DATA: begin
						state <= S_ADDR;
						// overrun drops the new pair, the one in flight is kept
						if (hs_idle) begin
							wr_cmd <= {addr_q, rx_byte};
							wr_req <= 1'b1;
						end
					end
					default: state <= S_ADDR;
				endcase
			end
		end
	end

	// the consumer may latch the command any time during the handshake
	a_cmd_stable: assert property (@(posedge CLK_IN) disable iff (!RSTn_i)
		wr_req |=> $stable(wr_cmd));

endmodule

// File: sid_board.sv
module sid_board
	import sid_pkg::*;
#(
	parameter int CLKS_PER_BIT = 16,	// short bit time for simulation
	parameter int SID_DIV      = 12,
	parameter int FIFO_DEPTH   = 4,
	parameter int DAC_W        = 8
) (
	input  logic CLK_IN,
	input  logic RSTn_i,
	input  logic rx,
	output logic audio_l,
	output logic audio_r
);

	logic             wr_req, wr_ack;	// assembler to fifo
	logic [CMD_W-1:0] wr_cmd;
	logic             rd_req, rd_ack;	// fifo to register banks
	logic [CMD_W-1:0] rd_cmd;
	logic [DAC_W-1:0] level_l, level_r;
	logic             ce_1m;

	cmd_assembler #(
		.CLKS_PER_BIT(CLKS_PER_BIT)
	) u_cmd_assembler (
		.CLK_IN(CLK_IN),
		.RSTn_i(RSTn_i),
		.rx    (rx),
		.wr_ack(wr_ack),
		.wr_req(wr_req),
		.wr_cmd(wr_cmd)
	);

	write_fifo #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) u_write_fifo (
		.CLK_IN(CLK_IN),
		.RSTn_i(RSTn_i),
		.wr_req(wr_req),
		.wr_cmd(wr_cmd),
		.rd_ack(rd_ack),
		.wr_ack(wr_ack),
		.rd_req(rd_req),
		.rd_cmd(rd_cmd)
	);

	sid_regbank #(
		.SID_DIV(SID_DIV),
		.DAC_W  (DAC_W)
	) u_sid_regbank (
		.CLK_IN (CLK_IN),
		.RSTn_i (RSTn_i),
		.rd_req (rd_req),
		.rd_cmd (rd_cmd),
		.rd_ack (rd_ack),
		.level_l(level_l),
		.level_r(level_r),
		.ce_1m  (ce_1m)
	);

	sigma_delta_dac #(.DAC_W(DAC_W)) u_dac_l (
		.CLK_IN(CLK_IN),
		.RSTn_i(RSTn_i),
		.ce_1m (ce_1m),
		.level (level_l),
		.audio (audio_l)
	);

	sigma_delta_dac #(.DAC_W(DAC_W)) u_dac_r (
		.CLK_IN(CLK_IN),
		.RSTn_i(RSTn_i),
		.ce_1m (ce_1m),
		.level (level_r),
		.audio (audio_r)
	);

endmodule

// File: sid_pkg.sv
package sid_pkg;

	// register address inside one chip, 32 registers
	localparam int REG_ADDR_W = 5;
	localparam int NUM_REGS = 1 << REG_ADDR_W;

	// data byte carried with every write
	localparam int DATA_W = 8;

	// command word is {chip select, register address, data}
	localparam int CMD_W = 1 + REG_ADDR_W + DATA_W;   // 14 bits
	localparam int CMD_DATA_LSB = 0;
	localparam int CMD_ADDR_LSB = DATA_W;              // register field starts above data
	localparam int CMD_SEL_BIT = CMD_W - 1;            // msb picks the chip

	// bit of the address byte that picks left (0) or right (1) chip
	localparam int CHIP_SEL_BIT = 5;

	// master volume lives in register 24, low nibble
	localparam int VOLUME_REG = 24;
	localparam int VOLUME_W = 4;

endpackage

// File: sid_regbank.sv
module sid_regbank
	import sid_pkg::*;
#(
	parameter int SID_DIV = 12,	// main cycles per chip cycle
	parameter int DAC_W   = 8
) (
	input  logic             CLK_IN,
	input  logic             RSTn_i,
	input  logic             rd_req,
	input  logic [CMD_W-1:0] rd_cmd,
	output logic             rd_ack,
	output logic [DAC_W-1:0] level_l,
	output logic [DAC_W-1:0] level_r,
	output logic             ce_1m
);

	localparam int DIV_W = $clog2(SID_DIV);

	if (DAC_W <= VOLUME_W)
		$error("sid_regbank needs DAC_W wider than the volume field");

	logic [DIV_W-1:0]      div_cnt;
	logic [DATA_W-1:0]     regs [2][NUM_REGS];	// left bank [0], right bank [1]
	logic                  wr_sel;
	logic [REG_ADDR_W-1:0] wr_addr;
	logic [DATA_W-1:0]     wr_data;
	logic                  wr_en;
	logic [VOLUME_W-1:0]   vol_l, vol_r;

	// command fields
	assign wr_sel  = rd_cmd[CMD_SEL_BIT];
	assign wr_addr = rd_cmd[CMD_ADDR_LSB +: REG_ADDR_W];
	assign wr_data = rd_cmd[CMD_DATA_LSB +: DATA_W];

	// chip clock enable, one cycle out of SID_DIV
	assign ce_1m = (div_cnt == '0);

	// take a write on the first enable that finds a request
	assign wr_en = ce_1m && rd_req && !rd_ack;

	assign vol_l = regs[0][VOLUME_REG][VOLUME_W-1:0];
	assign vol_r = regs[1][VOLUME_REG][VOLUME_W-1:0];	// high nibble ignored

	always_ff @(posedge CLK_IN) begin
		if (!RSTn_i)
			div_cnt <= DIV_W'(SID_DIV - 1);
		else
			div_cnt <= ce_1m ? DIV_W'(SID_DIV - 1) : div_cnt - 1'b1;
	end

	always_ff @(posedge CLK_IN) begin
		if (!RSTn_i) begin
			rd_ack <= 1'b0;
			for (int c = 0; c < 2; c++) begin
				for (int r = 0; r < NUM_REGS; r++)
					regs[c][r] <= '0;	// chip reset clears every register
			end
		end else begin
			if (wr_en) begin
				regs[wr_sel][wr_addr] <= wr_data;
				rd_ack                <= 1'b1;
			end else if (rd_ack && !rd_req) begin
				rd_ack <= 1'b0;	// fifo released req
			end
		end
	end

	// volume sets the dc level, scaled to the dac range
	always_ff @(posedge CLK_IN) begin
		if (!RSTn_i) begin
			level_l <= '0;
			level_r <= '0;
		end else begin
			level_l <= {vol_l, {(DAC_W - VOLUME_W){1'b0}}};
			level_r <= {vol_r, {(DAC_W - VOLUME_W){1'b0}}};
		end
	end

	// writes follow the chip clock, never the main clock
	a_ack_on_ce: assert property (@(posedge CLK_IN) disable iff (!RSTn_i)
		$rose(rd_ack) |-> $past(ce_1m));

endmodule

// File: sigma_delta_dac.sv
module sigma_delta_dac #(
	parameter int DAC_W = 8
) (
	input  logic             CLK_IN,
	input  logic             RSTn_i,
	input  logic             ce_1m,
	input  logic [DAC_W-1:0] level,
	output logic             audio
);

	logic [DAC_W:0] acc;		// carry bit is the output
	logic [1:0]     holdoff;	// chip cycles left before modulating

	// the carry comes out once per overflow of the low DAC_W bits
	assign audio = acc[DAC_W];

	always_ff @(posedge CLK_IN) begin
		if (!RSTn_i) begin
			holdoff <= 2'd3;
			acc     <= '0;
		end else if (holdoff != '0) begin
			acc <= '0;	// keep output low until the chip has settled
			if (ce_1m)
				holdoff <= holdoff - 1'b1;
		end else begin
			// first-order loop, old carry dropped, level added
			acc <= {1'b0, acc[DAC_W-1:0]} + {1'b0, level};
		end
	end

endmodule

// File: tb_checker.sv
module tb_checker #(
	parameter int DAC_W = 8
) (
	input  logic             CLK_IN,
	input  logic             audio_l,
	input  logic             audio_r,
	input  logic             start,		// measure request from the testbench top
	input  int               test_idx,
	input  logic [DAC_W-1:0] exp_l,		// expected ones per window
	input  logic [DAC_W-1:0] exp_r,
	output logic             done,
	output int               n_pass,
	output int               n_fail
);

	timeunit 1ns;
	timeprecision 1ps;

	localparam int WIN = 1 << DAC_W;	// one full dac window

	// a silent channel must stay low, anything else may be off by one
	function automatic bit level_ok(input int expected, input int measured);
		if (expected == 0)
			return measured == 0;
		return (measured >= expected - 1) && (measured <= expected + 1);
	endfunction

	task automatic report_mismatch(input string chan, input int expected, input int measured);
		$display("[ERROR] time %0t: %s expected %0d ones per window, measured %0d",
			$time, chan, expected, measured);
	endtask

	// everything runs on the falling edge, where the dac outputs are settled
	initial begin : measure_loop
		int cnt_l;
		int cnt_r;
		bit ok_l;
		bit ok_r;
		done   = 1'b0;
		n_pass = 0;
		n_fail = 0;
		forever begin
			@(negedge CLK_IN);
			if (start && !done) begin
				cnt_l = 0;
				cnt_r = 0;
				repeat (WIN) begin
					cnt_l += int'(audio_l);
					cnt_r += int'(audio_r);
					@(negedge CLK_IN);
				end
				ok_l = level_ok(int'(exp_l), cnt_l);
				ok_r = level_ok(int'(exp_r), cnt_r);
				if (!ok_l)
					report_mismatch("audio_l", int'(exp_l), cnt_l);
				if (!ok_r)
					report_mismatch("audio_r", int'(exp_r), cnt_r);
				if (ok_l && ok_r)
					n_pass++;
				else
					n_fail++;
				$display("test %0d: audio_l %0d/%0d  audio_r %0d/%0d  %s", test_idx,
					cnt_l, exp_l, cnt_r, exp_r, (ok_l && ok_r) ? "passed" : "failed");
				done = 1'b1;
			end else if (!start && done) begin
				done = 1'b0;	// request released, ready for the next one
			end
		end
	end

endmodule

// File: tb_sid_board.sv
module tb_sid_board
	import sid_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLKS_PER_BIT = 16;
	localparam int SID_DIV      = 12;
	localparam int FIFO_DEPTH   = 4;
	localparam int DAC_W        = 8;
	localparam int RST_CYCLES   = 10;
	localparam int NUM_TESTS    = 7;
	localparam int MAX_PAIRS    = 4;
	localparam int LAT_CYCLES   = 3 * SID_DIV + 8;	// data byte to new level on the dac
	localparam int WIN          = 1 << DAC_W;

	logic             CLK_IN;
	logic             RSTn_i;
	logic             rx;
	logic             audio_l, audio_r;
	logic             chk_start, chk_done;
	int               chk_idx;
	logic [DAC_W-1:0] chk_exp_l, chk_exp_r;
	int               n_pass, n_fail;

	// stimulus table, one row per test
	string            t_name   [NUM_TESTS];
	int               t_npairs [NUM_TESTS];
	logic [7:0]       t_addr   [NUM_TESTS][MAX_PAIRS];
	logic [7:0]       t_data   [NUM_TESTS][MAX_PAIRS];
	bit               t_bad    [NUM_TESTS][MAX_PAIRS];	// corrupt frame before the data byte
	logic [DAC_W-1:0] t_exp_l  [NUM_TESTS];
	logic [DAC_W-1:0] t_exp_r  [NUM_TESTS];

	logic [31:0] rng_q;
	int          cycle_cnt;
	int          cycle_limit;

	sid_board #(
		.CLKS_PER_BIT(CLKS_PER_BIT),
		.SID_DIV     (SID_DIV),
		.FIFO_DEPTH  (FIFO_DEPTH),
		.DAC_W       (DAC_W)
	) u_dut (
		.CLK_IN (CLK_IN),
		.RSTn_i (RSTn_i),
		.rx     (rx),
		.audio_l(audio_l),
		.audio_r(audio_r)
	);

	tb_checker #(.DAC_W(DAC_W)) u_checker (
		.CLK_IN  (CLK_IN),
		.audio_l (audio_l),
		.audio_r (audio_r),
		.start   (chk_start),
		.test_idx(chk_idx),
		.exp_l   (chk_exp_l),
		.exp_r   (chk_exp_r),
		.done    (chk_done),
		.n_pass  (n_pass),
		.n_fail  (n_fail)
	);

	initial CLK_IN = 1'b0;
	always #5 CLK_IN = ~CLK_IN;

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		s ^= s << 13;
		s ^= s >> 17;
		s ^= s << 5;
		return s;
	endfunction

	// volume nibble scaled into the dac range
	function automatic logic [DAC_W-1:0] vol_level(input int vol);
		return DAC_W'(vol << (DAC_W - VOLUME_W));
	endfunction

	function automatic logic [7:0] reg_addr(input int chip, input int regnum);
		return 8'((chip << CHIP_SEL_BIT) | regnum);	// bit 5 picks the right chip
	endfunction

	task automatic add_test(input int t, input string name, input logic [DAC_W-1:0] lvl_l,
		input logic [DAC_W-1:0] lvl_r);
		t_name[t]   = name;
		t_npairs[t] = 0;
		t_exp_l[t]  = lvl_l;
		t_exp_r[t]  = lvl_r;
	endtask

	task automatic add_pair(input int t, input logic [7:0] addr, input logic [7:0] data,
		input bit bad);
		t_addr[t][t_npairs[t]] = addr;
		t_data[t][t_npairs[t]] = data;
		t_bad[t][t_npairs[t]]  = bad;
		t_npairs[t]++;
	endtask

	task automatic build_table();
		int r;
		add_test(0, "reset_idle", '0, '0);
		add_test(1, "left_volume", vol_level(9), '0);
		add_pair(1, reg_addr(0, VOLUME_REG), 8'h09, 1'b0);
		add_test(2, "right_volume", vol_level(9), vol_level(5));
		add_pair(2, reg_addr(1, VOLUME_REG), 8'h05, 1'b0);
		add_test(3, "other_registers", vol_level(9), vol_level(5));
		for (int c = 0; c < 2; c++) begin
			rng_q = xorshift32(rng_q);
			r     = int'(rng_q[REG_ADDR_W-1:0]);
			if (r == VOLUME_REG)
				r = VOLUME_REG + 1;	// any register but volume
			rng_q = xorshift32(rng_q);
			add_pair(3, reg_addr(c, r), rng_q[7:0], 1'b0);
		end
		add_test(4, "volume_high_nibble", vol_level(9), vol_level(3));
		add_pair(4, reg_addr(1, VOLUME_REG), 8'hf3, 1'b0);
		add_test(5, "fifo_burst", vol_level(15), vol_level(3));
		add_pair(5, reg_addr(0, VOLUME_REG), 8'h01, 1'b0);
		add_pair(5, reg_addr(0, VOLUME_REG), 8'h02, 1'b0);
		add_pair(5, reg_addr(0, VOLUME_REG), 8'h03, 1'b0);
		add_pair(5, reg_addr(0, VOLUME_REG), 8'h0f, 1'b0);
		add_test(6, "bad_stop_bit", vol_level(7), vol_level(3));
		add_pair(6, reg_addr(0, VOLUME_REG), 8'h07, 1'b1);
	endtask

	// serial time of all frames plus wait and window per test, 25 percent margin
	function automatic int run_limit();
		int total;
		int bits;
		total = RST_CYCLES;
		for (int t = 0; t < NUM_TESTS; t++) begin
			bits = t_npairs[t] * 2 * 10;
			for (int p = 0; p < t_npairs[t]; p++)
				if (t_bad[t][p])
					bits += 11;	// extra frame and its idle bit
			total += bits * CLKS_PER_BIT + LAT_CYCLES + WIN + 8;
		end
		return total + total / 4;
	endfunction

	task automatic drive_bit(input logic value);
		@(posedge CLK_IN);
		rx <= value;
		repeat (CLKS_PER_BIT - 1) @(posedge CLK_IN);
	endtask

	// 8N1 frame, lsb first
	task automatic send_frame(input logic [7:0] value, input bit bad_stop);
		drive_bit(1'b0);
		for (int i = 0; i < 8; i++)
			drive_bit(value[i]);
		drive_bit(!bad_stop);
		if (bad_stop)
			drive_bit(1'b1);	// idle bit lets the receiver leave its break state
	endtask

	task automatic run_test(input int t);
		$display("running %s", t_name[t]);
		for (int p = 0; p < t_npairs[t]; p++) begin
			send_frame(t_addr[t][p], 1'b0);
			if (t_bad[t][p])
				send_frame(8'h5a, 1'b1);
			send_frame(t_data[t][p], 1'b0);
		end
		repeat (LAT_CYCLES) @(posedge CLK_IN);
		chk_idx   <= t;
		chk_exp_l <= t_exp_l[t];
		chk_exp_r <= t_exp_r[t];
		chk_start <= 1'b1;
		do @(posedge CLK_IN); while (!chk_done);	// four-phase with the checker
		chk_start <= 1'b0;
		do @(posedge CLK_IN); while (chk_done);
	endtask

	always @(posedge CLK_IN) begin
		cycle_cnt++;
		if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
			$display("timeout: run stopped after %0d cycles with tests still pending", cycle_cnt);
			$display("Test FAILED");
			$finish;
		end
	end

	initial begin
		RSTn_i      = 1'b0;
		rx          = 1'b1;	// idle line
		chk_start   = 1'b0;
		chk_idx     = 0;
		chk_exp_l   = '0;
		chk_exp_r   = '0;
		rng_q       = 32'hdc91;
		cycle_cnt   = 0;
		cycle_limit = 0;
		build_table();
		cycle_limit = run_limit();
		repeat (RST_CYCLES) @(posedge CLK_IN);
		RSTn_i <= 1'b1;
		for (int t = 0; t < NUM_TESTS; t++)
			run_test(t);
		$display("summary: %0d passed, %0d failed of %0d tests", n_pass, n_fail, NUM_TESTS);
		if (n_fail == 0 && n_pass == NUM_TESTS)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

// File: uart_rx.sv
module uart_rx #(
	parameter int CLKS_PER_BIT = 16	// main clocks per serial bit
) (
	input  logic       CLK_IN,
	input  logic       RSTn_i,
	input  logic       rx,
	output logic [7:0] rx_byte,
	output logic       rx_valid
);

	localparam int CNT_W = $clog2(CLKS_PER_BIT);
	localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(CLKS_PER_BIT - 1);
	localparam logic [CNT_W-1:0] CNT_HALF = CNT_W'(CLKS_PER_BIT / 2 - 1);

	typedef enum logic [2:0] {
		S_IDLE,
		S_START,
		S_DATA,
		S_STOP,
		S_BREAK	// bad stop bit, wait for line to go idle again
	} rx_state_t;

	rx_state_t        state;
	logic             rx_meta, rx_sync;	// two-flop synchronizer
	logic [CNT_W-1:0] clk_cnt;		// counts main clocks inside one bit
	logic [2:0]       bit_idx;
	logic [7:0]       shift_q;		// lsb first

	always_ff @(posedge CLK_IN) begin
		if (!RSTn_i) begin
			rx_meta <= 1'b1;	// idle line is high
			rx_sync <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
		end
	end

	always_ff @(posedge CLK_IN) begin
		if (!RSTn_i) begin
			state    <= S_IDLE;
			clk_cnt  <= '0;
			bit_idx  <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_valid <= 1'b0;	// strobe lasts one cycle
			clk_cnt  <= clk_cnt + 1'b1;
			case (state)
				S_IDLE: begin
					clk_cnt <= '0;
					if (!rx_sync)
						state <= S_START;	// falling edge, maybe a start bit
				end
				S_START: if (clk_cnt == CNT_HALF) begin
					clk_cnt <= '0;
					bit_idx <= '0;
					// glitch shorter than half a bit goes back to idle
					state   <= rx_sync ? S_IDLE : S_DATA;
				end
				S_DATA: if (clk_cnt == CNT_FULL) begin
					clk_cnt <= '0;
					shift_q <= {rx_sync, shift_q[7:1]};	// sample at mid-bit
					bit_idx <= bit_idx + 1'b1;
					if (bit_idx == 3'd7)
						state <= S_STOP;
				end
				S_STOP: if (clk_cnt == CNT_FULL) begin
					if (rx_sync) begin
						rx_byte  <= shift_q;
						rx_valid <= 1'b1;
						state    <= S_IDLE;
					end else begin
						state <= S_BREAK;	// framing error, frame dropped
					end
				end
				S_BREAK: if (rx_sync)
					state <= S_IDLE;
				default: state <= S_IDLE;
			endcase
		end
	end

	// a byte strobe is always followed by at least one quiet cycle
	a_valid_single: assert property (@(posedge CLK_IN) disable iff (!RSTn_i)
		rx_valid |=> !rx_valid);

endmodule

// File: write_fifo.sv
module write_fifo
	import sid_pkg::*;
#(
	parameter int FIFO_DEPTH = 4	// power of two
) (
	input  logic             CLK_IN,
	input  logic             RSTn_i,
	input  logic             wr_req,
	input  logic [CMD_W-1:0] wr_cmd,
	input  logic             rd_ack,
	output logic             wr_ack,
	output logic             rd_req,
	output logic [CMD_W-1:0] rd_cmd
);

	localparam int PTR_W = $clog2(FIFO_DEPTH);

	if (FIFO_DEPTH < 2 || (FIFO_DEPTH & (FIFO_DEPTH - 1)) != 0)
		$error("write_fifo needs a power of two depth of at least 2");

	logic [CMD_W-1:0] mem [FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr, rd_ptr;	// wrap on their own
	logic [PTR_W:0]   count;
	logic             full, empty;
	logic             rd_ack_d;		// for the rising edge of rd_ack
	logic             push, pop;

	assign full  = (count == (PTR_W + 1)'(FIFO_DEPTH));
	assign empty = (count == '0);

	// req without ack yet is a pending write, it waits here while full
	assign push = wr_req && !wr_ack && !full;
	assign pop  = rd_ack && !rd_ack_d;	// one pop per ack edge

	assign rd_cmd = mem[rd_ptr];	// head entry, stays put until the pop

	always_ff @(posedge CLK_IN) begin
		if (push)
			mem[wr_ptr] <= wr_cmd;
	end

	always_ff @(posedge CLK_IN) begin
		if (!RSTn_i) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			count    <= '0;
			wr_ack   <= 1'b0;
			rd_req   <= 1'b0;
			rd_ack_d <= 1'b0;
		end else begin
			rd_ack_d <= rd_ack;

			// write side
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
				wr_ack <= 1'b1;
			end else if (!wr_req && wr_ack) begin
				wr_ack <= 1'b0;	// producer released req
			end

			// read side
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
				rd_req <= 1'b0;
			end else if (!rd_req && !rd_ack && !empty) begin
				rd_req <= 1'b1;	// offer next entry once ack is low
			end

			count <= count + (push ? 1'b1 : 1'b0) - (pop ? 1'b1 : 1'b0);
		end
	end

	// a full buffer never acknowledges on the next edge
	a_no_push_full: assert property (@(posedge CLK_IN) disable iff (!RSTn_i)
		full |=> !$rose(wr_ack));

	// the consumer acks only entries that were offered
	a_no_pop_empty: assert property (@(posedge CLK_IN) disable iff (!RSTn_i)
		pop |-> !empty);

endmodule
